/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = tomasulo_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb.f */
verilog/sys_defs_pkg.sv
verilog/dispatch.sv
verilog/register_status.sv
verilog/rs.sv
verilog/execute.sv
verilog/tomasulo_core.sv
testbench/tomasulo_tb.sv

/* testbench/tomasulo_tb.sv */
module tomasulo_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int random_count = 40;
    localparam int total_insts = 20 + random_count;
    localparam int cycle_limit = 40 * total_insts + 100;

    localparam int op_add = 0;
    localparam int op_sub = 1;
    localparam int op_and = 2;
    localparam int op_or = 3;
    localparam int op_xor = 4;
    localparam int op_mul = 5;

    logic clock;
    logic reset;
    logic inst_valid;
    sys_defs_pkg::inst_t inst;
    logic inst_ready;
    sys_defs_pkg::cdb_packet_t cdb;
    sys_defs_pkg::reg_idx_t read_idx;
    logic [sys_defs_pkg::xlen-1:0] read_data;
    logic idle;

    // Program-order view of the register file
    logic [sys_defs_pkg::xlen-1:0] model [32];
    int errors;
    int checks;
    int stall_cycles;
    int cycles;

    tomasulo_core i_dut (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .cdb        (cdb),
        .read_idx   (read_idx),
        .read_data  (read_data),
        .idle       (idle)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    assert property (@(negedge clock) reset |-> !cdb.valid)
        else begin
            $display("cdb valid was high while reset was asserted");
            errors++;
        end

    assert property (@(negedge clock) disable iff (reset) idle |-> inst_ready)
        else begin
            $display("inst_ready was low while the core was idle");
            errors++;
        end

    // Cycles where an offered instruction is held back
    always @(negedge clock) begin
        if (inst_valid && !inst_ready) begin
            stall_cycles++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [sys_defs_pkg::xlen-1:0] apply_op(int op,
            logic [sys_defs_pkg::xlen-1:0] a, logic [sys_defs_pkg::xlen-1:0] b);
        case (op)
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_mul: return a * b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(int op);
        case (op)
            op_and: return 3'b111;
            op_or:  return 3'b110;
            op_xor: return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    // Offer one instruction until the core takes it
    task automatic drive_inst(sys_defs_pkg::inst_t word);
        logic taken;
        taken = 1'b0;
        inst = word;
        inst_valid = 1'b1;
        while (!taken) begin
            @(negedge clock);
            taken = inst_ready;
            next_cycle();
        end
        inst_valid = 1'b0;
    endtask

    task automatic send_r(int op, sys_defs_pkg::reg_idx_t rd,
            sys_defs_pkg::reg_idx_t rs1, sys_defs_pkg::reg_idx_t rs2);
        sys_defs_pkg::inst_t word;
        word = '0;
        word.r_view.opcode = 7'b0110011;
        word.r_view.rd = rd;
        word.r_view.rs1 = rs1;
        word.r_view.rs2 = rs2;
        word.r_view.funct3 = funct3_of(op);
        if (op == op_sub) begin
            word.r_view.funct7 = 7'b0100000;
        end else if (op == op_mul) begin
            word.r_view.funct7 = 7'b0000001;
        end
        if (rd != '0) begin
            model[rd] = apply_op(op, model[rs1], model[rs2]);
        end
        drive_inst(word);
    endtask

    task automatic send_i(int op, sys_defs_pkg::reg_idx_t rd,
            sys_defs_pkg::reg_idx_t rs1, logic [11:0] imm);
        sys_defs_pkg::inst_t word;
        word = '0;
        word.i_view.opcode = 7'b0010011;
        word.i_view.rd = rd;
        word.i_view.rs1 = rs1;
        word.i_view.imm = imm;
        word.i_view.funct3 = funct3_of(op);
        if (rd != '0) begin
            model[rd] = apply_op(op, model[rs1], {{20{imm[11]}}, imm});
        end
        drive_inst(word);
    endtask

    task automatic wait_idle();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clock);
            seen = idle;
            next_cycle();
        end
    endtask

    // Walk the debug port over all 32 registers
    task automatic check_regs(string test);
        for (int r = 0; r < 32; r++) begin
            read_idx = sys_defs_pkg::reg_idx_t'(r);
            @(negedge clock);
            checks++;
            assert (read_data == model[read_idx])
                else begin
                    $display("Fail %s: x%0d expected 0x%08h actual 0x%08h",
                             test, r, model[read_idx], read_data);
                    errors++;
                end
            next_cycle();
        end
    endtask

    task automatic random_program(int count);
        int kind;
        sys_defs_pkg::reg_idx_t rd;
        sys_defs_pkg::reg_idx_t rs1;
        sys_defs_pkg::reg_idx_t rs2;
        logic [11:0] imm;
        for (int n = 0; n < count; n++) begin
            kind = int'($urandom_range(9, 0));
            rd = sys_defs_pkg::reg_idx_t'($urandom_range(7, 0));
            rs1 = sys_defs_pkg::reg_idx_t'($urandom_range(7, 0));
            rs2 = sys_defs_pkg::reg_idx_t'($urandom_range(7, 0));
            imm = 12'($urandom());
            case (kind)
                6: send_i(op_add, rd, rs1, imm);
                7: send_i(op_and, rd, rs1, imm);
                8: send_i(op_or, rd, rs1, imm);
                9: send_i(op_xor, rd, rs1, imm);
                default: send_r(kind, rd, rs1, rs2);
            endcase
        end
    endtask

    initial begin
        int stall_before;
        void'($urandom(32'h3d0f_e9c9));
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        read_idx = '0;
        model = '{default: '0};
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;

        @(negedge clock);
        checks++;
        assert (idle && inst_ready && !cdb.valid)
            else begin
                $display("Fail reset: idle/inst_ready/cdb valid expected 1/1/0 actual %b/%b/%b",
                         idle, inst_ready, cdb.valid);
                errors++;
            end
        next_cycle();
        check_regs("reset");

        send_i(op_add, 5'd1, 5'd0, 12'h123);
        send_i(op_or, 5'd2, 5'd0, 12'h5a0);
        send_i(op_xor, 5'd3, 5'd0, 12'hfff);
        send_i(op_add, 5'd5, 5'd0, 12'h800);
        send_i(op_and, 5'd4, 5'd3, 12'h0f0);
        wait_idle();
        check_regs("immediate");

        // Every operand comes from the previous result
        send_r(op_add, 5'd6, 5'd1, 5'd2);
        send_r(op_sub, 5'd7, 5'd6, 5'd3);
        send_r(op_and, 5'd8, 5'd7, 5'd6);
        send_r(op_or, 5'd9, 5'd8, 5'd1);
        send_r(op_xor, 5'd10, 5'd9, 5'd7);
        send_r(op_add, 5'd11, 5'd10, 5'd10);
        wait_idle();
        check_regs("chain");

        // Late MUL must not overwrite the newer ADDI in x12
        // The wait on x19 makes the ADDI broadcast before the MUL
        send_r(op_add, 5'd19, 5'd1, 5'd1);
        send_r(op_mul, 5'd12, 5'd19, 5'd2);
        send_r(op_add, 5'd13, 5'd12, 5'd0);
        send_i(op_add, 5'd12, 5'd0, 12'h007);
        send_r(op_add, 5'd14, 5'd13, 5'd1);
        wait_idle();
        check_regs("ordering");

        stall_before = stall_cycles;
        send_r(op_mul, 5'd15, 5'd1, 5'd2);
        send_r(op_mul, 5'd16, 5'd3, 5'd4);
        send_r(op_mul, 5'd17, 5'd5, 5'd1);
        send_r(op_mul, 5'd18, 5'd2, 5'd2);
        wait_idle();
        check_regs("mul_stall");
        checks++;
        assert (stall_cycles > stall_before)
            else begin
                $display("inst_ready never dropped during the back-to-back MUL burst");
                errors++;
            end

        random_program(random_count);
        wait_idle();
        check_regs("random");

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/dispatch.sv */
module dispatch (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_valid,
    input  sys_defs_pkg::inst_t             inst,
    output logic                            inst_ready,
    input  logic                            alloc_done,
    output sys_defs_pkg::dispatch_packet_t  packet
);

    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // add x0, x0, x0
    localparam sys_defs_pkg::dispatch_packet_t nop = '{
        valid: 1'b1,
        fu_class: sys_defs_pkg::fu_alu,
        alu_op: sys_defs_pkg::alu_add,
        default: '0
    };

    sys_defs_pkg::dispatch_packet_t decoded;
    sys_defs_pkg::dispatch_packet_t pending;
    logic pending_valid;
    logic accept;

    always_comb begin
        decoded = nop;
        case (inst.r_view.opcode)
            opcode_op: begin
                decoded.dest = inst.r_view.rd;
                decoded.src1 = inst.r_view.rs1;
                decoded.src2 = inst.r_view.rs2;
                case ({inst.r_view.funct7, inst.r_view.funct3})
                    {7'b0000000, 3'b000}: decoded.alu_op = sys_defs_pkg::alu_add;
                    {7'b0100000, 3'b000}: decoded.alu_op = sys_defs_pkg::alu_sub;
                    {7'b0000000, 3'b111}: decoded.alu_op = sys_defs_pkg::alu_and;
                    {7'b0000000, 3'b110}: decoded.alu_op = sys_defs_pkg::alu_or;
                    {7'b0000000, 3'b100}: decoded.alu_op = sys_defs_pkg::alu_xor;
                    {7'b0000001, 3'b000}: begin
                        decoded.alu_op = sys_defs_pkg::alu_mul;
                        decoded.fu_class = sys_defs_pkg::fu_mul;
                    end
                    default: decoded = nop;
                endcase
            end
            opcode_op_imm: begin
                decoded.dest = inst.i_view.rd;
                decoded.src1 = inst.i_view.rs1;
                decoded.use_imm = 1'b1;
                decoded.imm = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};
                case (inst.i_view.funct3)
                    3'b000: decoded.alu_op = sys_defs_pkg::alu_add;
                    3'b111: decoded.alu_op = sys_defs_pkg::alu_and;
                    3'b110: decoded.alu_op = sys_defs_pkg::alu_or;
                    3'b100: decoded.alu_op = sys_defs_pkg::alu_xor;
                    default: decoded = nop;
                endcase
            end
            default: decoded = nop;
        endcase
    end

    // Room when empty or when the held packet leaves this cycle
    assign inst_ready = !pending_valid || alloc_done;
    assign accept = inst_valid && inst_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending_valid <= 1'b0;
        end else if (accept) begin
            pending_valid <= 1'b1;
        end else if (alloc_done) begin
            pending_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pending <= decoded;
        end
    end

    always_comb begin
        packet = pending;
        packet.valid = pending_valid;
    end

endmodule

/* verilog/execute.sv */
module execute (
    input  logic                            clock,
    input  logic                            reset,
    input  sys_defs_pkg::issue_packet_t     issue_alu,
    input  sys_defs_pkg::issue_packet_t     issue_mul,
    output logic                            alu_ready,
    output sys_defs_pkg::cdb_packet_t       cdb
);

    logic [sys_defs_pkg::xlen-1:0] alu_result;
    logic alu_valid;
    sys_defs_pkg::rs_tag_t alu_tag;
    logic [sys_defs_pkg::xlen-1:0] alu_value;

    // Multiplier stages 1 to 3
    logic [3:1] mul_valid;
    sys_defs_pkg::rs_tag_t mul_tag [1:3];
    logic [sys_defs_pkg::xlen-1:0] mul_a;
    logic [sys_defs_pkg::xlen-1:0] mul_b;
    logic [sys_defs_pkg::xlen-1:0] mul_prod [2:3];

    always_comb begin
        case (issue_alu.alu_op)
            sys_defs_pkg::alu_sub: alu_result = issue_alu.a - issue_alu.b;
            sys_defs_pkg::alu_and: alu_result = issue_alu.a & issue_alu.b;
            sys_defs_pkg::alu_or:  alu_result = issue_alu.a | issue_alu.b;
            sys_defs_pkg::alu_xor: alu_result = issue_alu.a ^ issue_alu.b;
            default:               alu_result = issue_alu.a + issue_alu.b;
        endcase
    end

    // The held ALU result either is empty or goes out this cycle
    assign alu_ready = !alu_valid || !mul_valid[3];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            if (issue_alu.valid) begin
                alu_valid <= 1'b1;
            end else if (!mul_valid[3]) begin
                alu_valid <= 1'b0;
            end
            mul_valid <= {mul_valid[2:1], issue_mul.valid};
        end
    end

    always_ff @(posedge clock) begin
        if (issue_alu.valid) begin
            alu_tag <= issue_alu.tag;
            alu_value <= alu_result;
        end
        mul_tag[1] <= issue_mul.tag;
        mul_a <= issue_mul.a;
        mul_b <= issue_mul.b;
        mul_tag[2] <= mul_tag[1];
        mul_prod[2] <= mul_a * mul_b;   // low word only
        mul_tag[3] <= mul_tag[2];
        mul_prod[3] <= mul_prod[2];
    end

    // Multiplier has the bus first since its pipeline cannot stall
    always_comb begin
        if (mul_valid[3]) begin
            cdb.valid = 1'b1;
            cdb.tag = mul_tag[3];
            cdb.value = mul_prod[3];
        end else begin
            cdb.valid = alu_valid;
            cdb.tag = alu_tag;
            cdb.value = alu_value;
        end
    end

endmodule

/* verilog/register_status.sv */
module register_status (
    input  logic                                clock,
    input  logic                                reset,
    input  sys_defs_pkg::reg_idx_t              src1,
    input  sys_defs_pkg::reg_idx_t              src2,
    output sys_defs_pkg::operand_t              op1,
    output sys_defs_pkg::operand_t              op2,
    input  logic                                alloc_done,
    input  sys_defs_pkg::rs_tag_t               alloc_tag,
    input  sys_defs_pkg::reg_idx_t              alloc_dest,
    input  sys_defs_pkg::cdb_packet_t           cdb,
    input  sys_defs_pkg::reg_idx_t              read_idx,
    output logic [sys_defs_pkg::xlen-1:0]       read_data
);

    logic [sys_defs_pkg::xlen-1:0] values [32];
    sys_defs_pkg::rs_tag_t tags [32];

    // Forward a result that is on the bus this very cycle
    function automatic sys_defs_pkg::operand_t lookup(sys_defs_pkg::reg_idx_t idx);
        sys_defs_pkg::operand_t op;
        op.value = values[idx];
        op.tag = tags[idx];
        if (op.tag != '0 && cdb.valid && cdb.tag == op.tag) begin
            op.value = cdb.value;
            op.tag = '0;
        end
        return op;
    endfunction

    assign op1 = lookup(src1);
    assign op2 = lookup(src2);
    assign read_data = values[read_idx];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                values[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // x0 is never allocated, so it stays zero
            for (int i = 1; i < 32; i++) begin
                if (cdb.valid && tags[i] != '0 && tags[i] == cdb.tag) begin
                    values[i] <= cdb.value;
                    tags[i] <= '0;
                end
                // A newer producer overrides the clear above
                if (alloc_done && alloc_dest == sys_defs_pkg::reg_idx_t'(i)) begin
                    tags[i] <= alloc_tag;
                end
            end
        end
    end

endmodule

/* verilog/rs.sv */
module rs #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  sys_defs_pkg::dispatch_packet_t  packet,
    input  sys_defs_pkg::operand_t          op1,
    input  sys_defs_pkg::operand_t          op2,
    output logic                            alloc_done,
    output sys_defs_pkg::rs_tag_t           alloc_tag,
    input  sys_defs_pkg::cdb_packet_t       cdb,
    input  logic                            alu_ready,
    output sys_defs_pkg::issue_packet_t     issue_alu,
    output sys_defs_pkg::issue_packet_t     issue_mul,
    output logic                            idle
);

    localparam int total = alu_entries + mul_entries;

    typedef struct packed {
        sys_defs_pkg::alu_op_t  alu_op;
        sys_defs_pkg::operand_t a;
        sys_defs_pkg::operand_t b;
    } entry_t;

    entry_t entries [1:total];
    logic [total:1] busy;
    logic [total:1] issued;
    logic [total:1] ready;
    sys_defs_pkg::operand_t op2_sel;

    function automatic sys_defs_pkg::rs_tag_t tag_of(int idx);
        return sys_defs_pkg::rs_tag_t'(idx);
    endfunction

    // Low entries feed the ALU, the rest the multiplier
    function automatic sys_defs_pkg::fu_class_t class_of(int idx);
        return (idx <= alu_entries) ? sys_defs_pkg::fu_alu : sys_defs_pkg::fu_mul;
    endfunction

    function automatic sys_defs_pkg::issue_packet_t make_issue(int idx);
        sys_defs_pkg::issue_packet_t p;
        p.valid = 1'b1;
        p.tag = tag_of(idx);
        p.alu_op = entries[idx].alu_op;
        p.a = entries[idx].a.value;
        p.b = entries[idx].b.value;
        return p;
    endfunction

    // Lowest free entry of the packet's class
    always_comb begin
        alloc_tag = '0;
        for (int i = total; i >= 1; i--) begin
            if (!busy[i] && class_of(i) == packet.fu_class) begin
                alloc_tag = tag_of(i);
            end
        end
        alloc_done = packet.valid && alloc_tag != '0;
    end

    always_comb begin
        op2_sel = op2;
        if (packet.use_imm) begin
            op2_sel.value = packet.imm;
            op2_sel.tag = '0;
        end
    end

    always_comb begin
        for (int i = 1; i <= total; i++) begin
            ready[i] = busy[i] && !issued[i]
                       && entries[i].a.tag == '0 && entries[i].b.tag == '0;
        end
    end

    // Walk downward so the lowest ready index wins per unit
    always_comb begin
        issue_alu = '0;
        issue_mul = '0;
        for (int i = total; i >= 1; i--) begin
            if (ready[i] && class_of(i) == sys_defs_pkg::fu_alu) begin
                issue_alu = make_issue(i);
                issue_alu.valid = alu_ready;
            end else if (ready[i]) begin
                issue_mul = make_issue(i);
            end
        end
    end

    assign idle = !packet.valid && busy == '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
            issued <= '0;
        end else begin
            for (int i = 1; i <= total; i++) begin
                if (alloc_done && alloc_tag == tag_of(i)) begin
                    busy[i] <= 1'b1;
                    issued[i] <= 1'b0;
                end else if (cdb.valid && cdb.tag == tag_of(i)) begin
                    // Own result on the bus, entry and tag become free
                    busy[i] <= 1'b0;
                    issued[i] <= 1'b0;
                end else if ((issue_alu.valid && issue_alu.tag == tag_of(i))
                             || (issue_mul.valid && issue_mul.tag == tag_of(i))) begin
                    issued[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 1; i <= total; i++) begin
            if (alloc_done && alloc_tag == tag_of(i)) begin
                entries[i].alu_op <= packet.alu_op;
                entries[i].a <= op1;
                entries[i].b <= op2_sel;
            end else begin
                // Capture waiting operands from the bus
                if (cdb.valid && entries[i].a.tag != '0 && entries[i].a.tag == cdb.tag) begin
                    entries[i].a.value <= cdb.value;
                    entries[i].a.tag <= '0;
                end
                if (cdb.valid && entries[i].b.tag != '0 && entries[i].b.tag == cdb.tag) begin
                    entries[i].b.value <= cdb.value;
                    entries[i].b.tag <= '0;
                end
            end
        end
    end

endmodule

/* verilog/sys_defs_pkg.sv */
package sys_defs_pkg;

    localparam int xlen = 32;
    localparam int tag_bits = 3;

    // Tag 0 means the operand value is already present
    typedef logic [tag_bits-1:0] rs_tag_t;
    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } inst_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_mul
    } alu_op_t;

    typedef enum logic {
        fu_alu,
        fu_mul
    } fu_class_t;

    typedef struct packed {
        logic              valid;
        fu_class_t         fu_class;
        alu_op_t           alu_op;
        reg_idx_t          dest;
        reg_idx_t          src1;
        reg_idx_t          src2;
        logic              use_imm;
        logic [xlen-1:0]   imm;
    } dispatch_packet_t;

    typedef struct packed {
        logic [xlen-1:0] value;
        rs_tag_t         tag;
    } operand_t;

    typedef struct packed {
        logic            valid;
        rs_tag_t         tag;
        alu_op_t         alu_op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } issue_packet_t;

    typedef struct packed {
        logic            valid;
        rs_tag_t         tag;
        logic [xlen-1:0] value;
    } cdb_packet_t;

endpackage

/* verilog/tomasulo_core.sv */
module tomasulo_core #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_valid,
    input  sys_defs_pkg::inst_t             inst,
    output logic                            inst_ready,
    output sys_defs_pkg::cdb_packet_t       cdb,
    input  sys_defs_pkg::reg_idx_t          read_idx,
    output logic [sys_defs_pkg::xlen-1:0]   read_data,
    output logic                            idle
);

    sys_defs_pkg::dispatch_packet_t packet;
    sys_defs_pkg::operand_t op1;
    sys_defs_pkg::operand_t op2;
    logic alloc_done;
    sys_defs_pkg::rs_tag_t alloc_tag;
    sys_defs_pkg::issue_packet_t issue_alu;
    sys_defs_pkg::issue_packet_t issue_mul;
    logic alu_ready;

    dispatch u_dispatch (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .alloc_done (alloc_done),
        .packet     (packet)
    );

    register_status u_register_status (
        .clock      (clock),
        .reset      (reset),
        .src1       (packet.src1),
        .src2       (packet.src2),
        .op1        (op1),
        .op2        (op2),
        .alloc_done (alloc_done),
        .alloc_tag  (alloc_tag),
        .alloc_dest (packet.dest),
        .cdb        (cdb),
        .read_idx   (read_idx),
        .read_data  (read_data)
    );

    rs #(
        .alu_entries (alu_entries),
        .mul_entries (mul_entries)
    ) u_rs (
        .clock      (clock),
        .reset      (reset),
        .packet     (packet),
        .op1        (op1),
        .op2        (op2),
        .alloc_done (alloc_done),
        .alloc_tag  (alloc_tag),
        .cdb        (cdb),
        .alu_ready  (alu_ready),
        .issue_alu  (issue_alu),
        .issue_mul  (issue_mul),
        .idle       (idle)
    );

    execute u_execute (
        .clock      (clock),
        .reset      (reset),
        .issue_alu  (issue_alu),
        .issue_mul  (issue_mul),
        .alu_ready  (alu_ready),
        .cdb        (cdb)
    );

endmodule
